//--- atom.f
atom_pkg.sv
atom_fetch.sv
atom_decode.sv
atom_regfile.sv
atom_alu.sv
atom_branch_cmp.sv
atom_core.sv
atom_chk.sv
atom_tb.sv

//--- Makefile
# Verilator simulation of the atom core testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module atom_tb -f atom.f
	out=$$(./obj_dir/Vatom_tb); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- atom_tb.sv
// Atom core testbench
// Runs a table of short programs through the core, first with
// immediate acks and then with LFSR-stretched acks on both ports,
// and checks the first store that each program makes

module atom_tb import atom_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] imem_addr;
    logic [31:0] imem_data = INSTR_NOP;
    logic        imem_valid;
    logic        imem_ack = 1'b0;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_data;
    logic        dmem_we;
    logic        dmem_valid;
    logic        dmem_ack = 1'b0;

    string       test_name [8];
    logic [31:0] test_prog [8][8];  // Up to 8 words per program
    logic [31:0] exp_addr  [8];
    logic [31:0] exp_data  [8];

    logic [31:0] imem [8];          // Program of the running test
    logic [31:0] lfsr = 32'heddd;
    logic        rand_acks = 1'b0;  // Stretch acks when set
    logic [1:0]  imem_wait = 2'd0;
    logic [1:0]  dmem_wait = 2'd0;
    int          store_cnt = 0;
    logic [31:0] store_addr = '0;
    logic [31:0] store_data = '0;
    int          passed = 0;
    int          failed = 0;

    always #50 clk = ~clk;          // 100 ns period

    atom_core atom_core_inst (
        .clk_i        (clk),
        .rst_i        (rst),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .imem_valid_o (imem_valid),
        .imem_ack_i   (imem_ack),
        .dmem_addr_o  (dmem_addr),
        .dmem_data_o  (dmem_data),
        .dmem_we_o    (dmem_we),
        .dmem_valid_o (dmem_valid),
        .dmem_ack_i   (dmem_ack)
    );

    ////////////////////////////////////////////////////////////////////////////
    // RV32I instruction encoders
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};  // sw
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input int imm20, input int rd,
                                           input logic [6:0] opc);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Ack delay of 0..3 cycles from one LFSR step per bit
    function automatic logic [1:0] draw_delay();
        logic [1:0] d;
        d = 2'd0;
        if (!rand_acks) begin
            return d;
        end
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_next(lfsr);
            d    = {d[0], lfsr[0]};
        end
        return d;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program table with expected values worked out by hand from the ISA
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_table();
        logic [31:0] nop;
        logic [31:0] halt;
        nop  = INSTR_NOP;
        halt = j_type(0, 0);                        // jal x0,0
        test_name[0] = "alu_chain";                 // ((100 - -3) ^ -3) + 100
        test_prog[0] = '{i_type(100, 0, 0, 1, OPC_OP_IMM), i_type(-3, 0, 0, 2, OPC_OP_IMM),
                         r_type(32, 2, 1, 0, 3), r_type(0, 2, 3, 4, 4),
                         r_type(0, 1, 4, 0, 5), s_type(8, 5, 1), halt, nop};
        exp_addr[0]  = 32'h0000_006c;
        exp_data[0]  = 32'hffff_fffe;
        test_name[1] = "shifts";                    // (0x5a5 << 21) >>> 9
        test_prog[1] = '{i_type(1445, 0, 0, 1, OPC_OP_IMM), i_type(21, 0, 0, 2, OPC_OP_IMM),
                         r_type(0, 2, 1, 1, 3), i_type(9, 0, 0, 6, OPC_OP_IMM),
                         r_type(32, 6, 3, 5, 4), s_type(32, 4, 0), halt, nop};
        exp_addr[1]  = 32'h0000_0020;
        exp_data[1]  = 32'hffda_5000;
        test_name[2] = "beq_taken";                 // Skips x1 = 99
        test_prog[2] = '{i_type(3, 0, 0, 1, OPC_OP_IMM), i_type(3, 0, 0, 2, OPC_OP_IMM),
                         b_type(8, 2, 1, 0), i_type(99, 0, 0, 1, OPC_OP_IMM),
                         s_type(16, 1, 0), halt, nop, nop};
        exp_addr[2]  = 32'h0000_0010;
        exp_data[2]  = 32'h0000_0003;
        test_name[3] = "bne_untaken";               // Falls through to x1 = 99
        test_prog[3] = '{i_type(3, 0, 0, 1, OPC_OP_IMM), i_type(3, 0, 0, 2, OPC_OP_IMM),
                         b_type(8, 2, 1, 1), i_type(99, 0, 0, 1, OPC_OP_IMM),
                         s_type(20, 1, 0), halt, nop, nop};
        exp_addr[3]  = 32'h0000_0014;
        exp_data[3]  = 32'h0000_0063;
        test_name[4] = "blt_taken";                 // -5 < 2 signed
        test_prog[4] = '{i_type(-5, 0, 0, 1, OPC_OP_IMM), i_type(2, 0, 0, 2, OPC_OP_IMM),
                         b_type(8, 2, 1, 4), i_type(77, 0, 0, 1, OPC_OP_IMM),
                         s_type(24, 1, 0), halt, nop, nop};
        exp_addr[4]  = 32'h0000_0018;
        exp_data[4]  = 32'hffff_fffb;
        test_name[5] = "jal_link";                  // jal at 4 with link 8
        test_prog[5] = '{i_type(1, 0, 0, 5, OPC_OP_IMM), j_type(8, 1),
                         i_type(55, 0, 0, 1, OPC_OP_IMM), s_type(40, 1, 0), halt, nop, nop, nop};
        exp_addr[5]  = 32'h0000_0028;
        exp_data[5]  = 32'h0000_0008;
        test_name[6] = "jalr_link";                 // jalr at 4 to 16 with link 8
        test_prog[6] = '{i_type(16, 0, 0, 2, OPC_OP_IMM), i_type(0, 2, 0, 1, OPC_JALR),
                         i_type(55, 0, 0, 1, OPC_OP_IMM), i_type(66, 0, 0, 1, OPC_OP_IMM),
                         s_type(44, 1, 0), halt, nop, nop};
        exp_addr[6]  = 32'h0000_002c;
        exp_data[6]  = 32'h0000_0008;
        test_name[7] = "upper_sltu";                // 0x12345000 + (x1 <u -1) to 0x1004 + 4
        test_prog[7] = '{u_type(32'h12345, 1, OPC_LUI), u_type(1, 2, OPC_AUIPC),
                         i_type(-1, 0, 0, 5, OPC_OP_IMM), r_type(0, 5, 1, 3, 3),
                         r_type(0, 3, 1, 0, 4), s_type(4, 4, 2), halt, nop};
        exp_addr[7]  = 32'h0000_1008;
        exp_data[7]  = 32'h1234_5001;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory models drive data and acks on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        imem_data = (imem_addr < 32'd32) ? imem[imem_addr[4:2]] : INSTR_NOP;
        if (imem_wait == 2'd0) begin
            imem_ack  = 1'b1;
            imem_wait = draw_delay();
        end else begin
            imem_ack  = 1'b0;
            imem_wait = imem_wait - 2'd1;
        end
        if (dmem_valid && dmem_wait == 2'd0) begin
            dmem_ack  = 1'b1;
            dmem_wait = draw_delay();
        end else begin
            dmem_ack  = 1'b0;
            if (dmem_valid) begin
                dmem_wait = dmem_wait - 2'd1;       // Count only while a store waits
            end
        end
    end

    // Write transfers captured like a flop
    always @(posedge clk) begin
        if (dmem_valid && dmem_we && dmem_ack) begin
            store_cnt  <= store_cnt + 1;
            store_addr <= dmem_addr;
            store_data <= dmem_data;
        end
    end

    // Reload, reset, then wait for the first store
    task automatic run_test(input int t);
        int   start;
        int   cycles;
        logic ok;
        logic valid_low;
        ok = 1'b1;
        for (int i = 0; i < 8; i++) begin
            imem[i] = test_prog[t][i];
        end
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        assert (imem_addr == RESET_PC) else begin
            $display("Fail %s: first fetch expected %h actual %h", test_name[t], RESET_PC,
                     imem_addr);
            ok = 1'b0;
        end
        start     = store_cnt;
        cycles    = 0;
        valid_low = 1'b0;
        while (store_cnt == start && cycles < 500) begin
            @(negedge clk);
            cycles++;
            if (!imem_valid) begin
                valid_low = 1'b1;                   // Fetch request dropped
            end
        end
        assert (!valid_low) else begin
            $display("Test %s: imem valid went low outside reset", test_name[t]);
            ok = 1'b0;
        end
        if (store_cnt == start) begin
            $display("Test %s timed out: the core made no store within 500 cycles",
                     test_name[t]);
            ok = 1'b0;
        end else begin
            assert (store_addr == exp_addr[t]) else begin
                $display("Fail %s: store address expected %h actual %h", test_name[t],
                         exp_addr[t], store_addr);
                ok = 1'b0;
            end
            assert (store_data == exp_data[t]) else begin
                $display("Fail %s: store data expected %h actual %h", test_name[t],
                         exp_data[t], store_data);
                ok = 1'b0;
            end
        end
        if (ok) begin
            passed++;
            $display("Pass %s with %s acks", test_name[t], rand_acks ? "random" : "fixed");
        end else begin
            failed++;
        end
    endtask

    initial begin
        build_table();
        for (int round = 0; round < 2; round++) begin
            @(posedge clk);
            rand_acks = (round == 1);               // Second round stretches acks
            @(negedge clk);
            for (int t = 0; t < $size(test_name); t++) begin
                run_test(t);
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- atom_chk.sv
// Atom core memory port checks
// Concurrent assertions on the imem and dmem handshakes,
// bound into every atom_core instance

module atom_chk import atom_pkg::*; (
    input logic            clk_i,
    input logic            rst_i,
    input logic            imem_valid_i,
    input logic [XLEN-1:0] dmem_addr_i,
    input logic [XLEN-1:0] dmem_data_i,
    input logic            dmem_we_i,
    input logic            dmem_valid_i,
    input logic            dmem_ack_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // No fetch request while in reset
    imem_idle_in_reset: assert property (@(posedge clk_i) rst_i |-> !imem_valid_i)
        else $error("imem valid high during reset");

    // Store held steady until acked
    dmem_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (dmem_valid_i && !dmem_ack_i) |=> ($stable(dmem_addr_i) && $stable(dmem_data_i)))
        else $error("dmem address or data changed before ack");

    dmem_aligned: assert property (@(posedge clk_i) dmem_valid_i |-> dmem_addr_i[1:0] == 2'b00)
        else $error("dmem address not word aligned");

    // Write-only port
    dmem_we_match: assert property (@(posedge clk_i) dmem_we_i == dmem_valid_i)
        else $error("dmem write enable differs from valid");

endmodule

bind atom_core atom_chk atom_chk_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .imem_valid_i (imem_valid_o),
    .dmem_addr_i  (dmem_addr_o),
    .dmem_data_i  (dmem_data_o),
    .dmem_we_i    (dmem_we_o),
    .dmem_valid_i (dmem_valid_o),
    .dmem_ack_i   (dmem_ack_i)
);

//--- atom_core.sv
// Atom two-stage RV32I core, top level
// Stage 1 fetches over the imem valid/ack port, stage 2 decodes,
// executes and writes back; word stores leave on the dmem port

module atom_core import atom_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    // Instruction port
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_data_i,
    output logic            imem_valid_o,
    input  logic            imem_ack_i,
    // Data port, write only
    output logic [XLEN-1:0] dmem_addr_o,
    output logic [XLEN-1:0] dmem_data_o,
    output logic            dmem_we_o,
    output logic            dmem_valid_o,
    input  logic            dmem_ack_i
);

    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       pc_old;
    logic [XLEN-1:0]       link_addr;
    logic                  stall_s2;
    logic                  jump;

    logic [REG_ADDR_W-1:0] rd_sel;
    logic [REG_ADDR_W-1:0] rs1_sel;
    logic [REG_ADDR_W-1:0] rs2_sel;
    logic [XLEN-1:0]       imm;
    logic                  jump_en;
    cmp_op_e               cmp_op;
    logic                  rf_we;
    wb_sel_e               wb_sel;
    logic                  a_pc_sel;
    logic                  b_imm_sel;
    logic                  cmp_b_imm_sel;
    alu_op_e               alu_op;
    logic                  store;

    logic [XLEN-1:0]       rs1;
    logic [XLEN-1:0]       rs2;
    logic [XLEN-1:0]       rd_data;
    logic [XLEN-1:0]       alu_a;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       cmp_b;
    logic                  cmp_taken;

    // Store waiting for its ack holds the whole pipe
    assign stall_s2 = dmem_valid_o && !dmem_ack_i;
    assign jump     = jump_en && cmp_taken;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1
    ////////////////////////////////////////////////////////////////////////////
    atom_fetch atom_fetch_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .imem_addr_o   (imem_addr_o),
        .imem_valid_o  (imem_valid_o),
        .imem_data_i   (imem_data_i),
        .imem_ack_i    (imem_ack_i),
        .jump_i        (jump),
        .jump_target_i (alu_result),    // pc/rs1 + imm
        .stall_ex_i    (stall_s2),
        .instr_o       (instr),
        .pc_old_o      (pc_old),
        .link_addr_o   (link_addr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2
    ////////////////////////////////////////////////////////////////////////////
    atom_decode atom_decode_inst (
        .instr_i         (instr),
        .rd_sel_o        (rd_sel),
        .rs1_sel_o       (rs1_sel),
        .rs2_sel_o       (rs2_sel),
        .imm_o           (imm),
        .jump_en_o       (jump_en),
        .cmp_op_o        (cmp_op),
        .rf_we_o         (rf_we),
        .wb_sel_o        (wb_sel),
        .a_pc_sel_o      (a_pc_sel),
        .b_imm_sel_o     (b_imm_sel),
        .cmp_b_imm_sel_o (cmp_b_imm_sel),
        .alu_op_o        (alu_op),
        .store_o         (store)
    );

    // Write-back source
    always_comb begin
        case (wb_sel)
            WB_IMM:  rd_data = imm;
            WB_LINK: rd_data = link_addr;
            WB_CMP:  rd_data = {{(XLEN-1){1'b0}}, cmp_taken};
            default: rd_data = alu_result;
        endcase
    end

    atom_regfile atom_regfile_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rs1_sel_i (rs1_sel),
        .rs2_sel_i (rs2_sel),
        .rd_sel_i  (rd_sel),
        .we_i      (rf_we && !stall_s2),    // No write while stalled
        .rd_data_i (rd_data),
        .rs1_o     (rs1),
        .rs2_o     (rs2)
    );

    // Operand selects
    assign alu_a = a_pc_sel      ? pc_old : rs1;
    assign alu_b = b_imm_sel     ? imm    : rs2;
    assign cmp_b = cmp_b_imm_sel ? imm    : rs2;

    atom_alu atom_alu_inst (
        .a_i      (alu_a),
        .b_i      (alu_b),
        .op_i     (alu_op),
        .result_o (alu_result)
    );

    atom_branch_cmp atom_branch_cmp_inst (
        .a_i     (rs1),
        .b_i     (cmp_b),
        .op_i    (cmp_op),
        .taken_o (cmp_taken)
    );

    // Store port, word accesses only
    assign dmem_addr_o  = {alu_result[XLEN-1:2], 2'b00};
    assign dmem_data_o  = rs2;
    assign dmem_valid_o = store;
    assign dmem_we_o    = store;

endmodule

//--- atom_branch_cmp.sv
// Atom branch comparator
// Signed and unsigned compare for branches and slt/sltu;
// ALWAYS serves jal/jalr, NEVER everything else

module atom_branch_cmp import atom_pkg::*; (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  cmp_op_e         op_i,
    output logic            taken_o
);

    always_comb begin
        case (op_i)
            CMP_ALWAYS: taken_o = 1'b1;
            CMP_EQ:     taken_o = (a_i == b_i);
            CMP_NE:     taken_o = (a_i != b_i);
            CMP_LT:     taken_o = ($signed(a_i) < $signed(b_i));
            CMP_GE:     taken_o = ($signed(a_i) >= $signed(b_i));
            CMP_LTU:    taken_o = (a_i < b_i);
            CMP_GEU:    taken_o = (a_i >= b_i);
            default:    taken_o = 1'b0;     // CMP_NEVER
        endcase
    end

endmodule

//--- atom_alu.sv
// Atom ALU
// Add, subtract, shifts, set-less-than and the bitwise functions
// of RV32I, purely combinational

module atom_alu import atom_pkg::*; (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  alu_op_e         op_i,
    output logic [XLEN-1:0] result_o
);

    logic [4:0] shamt;  // Only the low five bits count

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = XLEN'($signed(a_i) < $signed(b_i));
            ALU_SLTU: result_o = XLEN'(a_i < b_i);
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);  // Sign fill
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = '0;
        endcase
    end

endmodule

//--- atom_regfile.sv
// Atom register file
// x0..x31 with two combinational reads and one clocked write,
// x0 reads as zero and ignores writes

module atom_regfile import atom_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [REG_ADDR_W-1:0] rs1_sel_i,
    input  logic [REG_ADDR_W-1:0] rs2_sel_i,
    input  logic [REG_ADDR_W-1:0] rd_sel_i,
    input  logic                  we_i,
    input  logic [XLEN-1:0]       rd_data_i,
    output logic [XLEN-1:0]       rs1_o,
    output logic [XLEN-1:0]       rs2_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_sel_i != '0) begin
            regs[rd_sel_i] <= rd_data_i;
        end
    end

    // Read ports, x0 forced to zero
    assign rs1_o = (rs1_sel_i == '0) ? '0 : regs[rs1_sel_i];
    assign rs2_o = (rs2_sel_i == '0) ? '0 : regs[rs2_sel_i];

endmodule

//--- atom_decode.sv
// Atom instruction decoder
// Splits the instruction register into register selects, a sign
// extended immediate and the control fields for stage 2.
// Loads, narrow stores, SYSTEM and FENCE come out as nops

module atom_decode import atom_pkg::*; (
    input  logic [XLEN-1:0]       instr_i,
    output logic [REG_ADDR_W-1:0] rd_sel_o,
    output logic [REG_ADDR_W-1:0] rs1_sel_o,
    output logic [REG_ADDR_W-1:0] rs2_sel_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  jump_en_o,        // Jump if comparator agrees
    output cmp_op_e               cmp_op_o,
    output logic                  rf_we_o,
    output wb_sel_e               wb_sel_o,
    output logic                  a_pc_sel_o,       // ALU a = pc instead of rs1
    output logic                  b_imm_sel_o,      // ALU b = imm instead of rs2
    output logic                  cmp_b_imm_sel_o,  // Comparator b = imm
    output alu_op_e               alu_op_o,
    output logic                  store_o           // Word store
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;           // instr[30], sub / sra
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign alt       = instr_i[30];
    assign rd_sel_o  = instr_i[11:7];
    assign rs1_sel_o = instr_i[19:15];
    assign rs2_sel_o = instr_i[24:20];

    ////////////////////////////////////////////////////////////////////////////
    // Immediate formats
    ////////////////////////////////////////////////////////////////////////////
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        // Nop defaults
        imm_o           = '0;
        jump_en_o       = 1'b0;
        cmp_op_o        = CMP_NEVER;
        rf_we_o         = 1'b0;
        wb_sel_o        = WB_ALU;
        a_pc_sel_o      = 1'b0;
        b_imm_sel_o     = 1'b0;
        cmp_b_imm_sel_o = 1'b0;
        alu_op_o        = ALU_ADD;
        store_o         = 1'b0;

        case (opcode)
            OPC_LUI: begin
                imm_o    = imm_u;
                rf_we_o  = 1'b1;
                wb_sel_o = WB_IMM;
            end
            OPC_AUIPC: begin
                imm_o       = imm_u;
                rf_we_o     = 1'b1;
                a_pc_sel_o  = 1'b1;                 // pc + imm
                b_imm_sel_o = 1'b1;
            end
            OPC_JAL: begin
                imm_o       = imm_j;
                jump_en_o   = 1'b1;
                cmp_op_o    = CMP_ALWAYS;
                rf_we_o     = 1'b1;
                wb_sel_o    = WB_LINK;
                a_pc_sel_o  = 1'b1;                 // Target pc + imm
                b_imm_sel_o = 1'b1;
            end
            OPC_JALR: begin
                imm_o       = imm_i;
                jump_en_o   = 1'b1;
                cmp_op_o    = CMP_ALWAYS;
                rf_we_o     = 1'b1;
                wb_sel_o    = WB_LINK;
                b_imm_sel_o = 1'b1;                 // Target rs1 + imm
            end
            OPC_BRANCH: begin
                imm_o       = imm_b;
                jump_en_o   = 1'b1;
                a_pc_sel_o  = 1'b1;
                b_imm_sel_o = 1'b1;
                case (funct3)
                    3'b000:  cmp_op_o = CMP_EQ;
                    3'b001:  cmp_op_o = CMP_NE;
                    3'b100:  cmp_op_o = CMP_LT;
                    3'b101:  cmp_op_o = CMP_GE;
                    3'b110:  cmp_op_o = CMP_LTU;
                    3'b111:  cmp_op_o = CMP_GEU;
                    default: cmp_op_o = CMP_NEVER;  // Reserved funct3
                endcase
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin         // sw only
                    imm_o       = imm_s;
                    b_imm_sel_o = 1'b1;             // Address rs1 + imm
                    store_o     = 1'b1;
                end
            end
            OPC_OP, OPC_OP_IMM: begin
                rf_we_o         = 1'b1;
                b_imm_sel_o     = (opcode == OPC_OP_IMM);
                cmp_b_imm_sel_o = (opcode == OPC_OP_IMM);
                imm_o           = imm_i;
                case (funct3)
                    3'b000:  alu_op_o = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op_o = ALU_SLL;
                    3'b010: begin                   // slt through the comparator
                        wb_sel_o = WB_CMP;
                        cmp_op_o = CMP_LT;
                    end
                    3'b011: begin
                        wb_sel_o = WB_CMP;
                        cmp_op_o = CMP_LTU;
                    end
                    3'b100:  alu_op_o = ALU_XOR;
                    3'b101:  alu_op_o = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op_o = ALU_OR;
                    default: alu_op_o = ALU_AND;
                endcase
            end
            default: ;  // Everything else behaves as a nop
        endcase
    end

endmodule

//--- atom_fetch.sv
// Atom fetch stage
// Program counter, stage-2 pipeline registers and the stall/flush
// control around the imem valid/ack handshake

module atom_fetch import atom_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    output logic [XLEN-1:0] imem_addr_o,
    output logic            imem_valid_o,
    input  logic [XLEN-1:0] imem_data_i,
    input  logic            imem_ack_i,
    input  logic            jump_i,         // Taken jump/branch in stage 2
    input  logic [XLEN-1:0] jump_target_i,
    input  logic            stall_ex_i,     // Stage 2 waiting on dmem ack
    output logic [XLEN-1:0] instr_o,
    output logic [XLEN-1:0] pc_old_o,       // Address of instr_o
    output logic [XLEN-1:0] link_addr_o     // pc_old_o + 4
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus_four;
    logic            ignore_hs;     // Drop the fetch in flight after a jump
    logic            raw_hs;
    logic            imem_hs;
    logic            stall_s1;
    logic            flush;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake, stall and flush
    ////////////////////////////////////////////////////////////////////////////
    assign imem_valid_o = !rst_i;                   // Always requesting
    assign raw_hs       = imem_valid_o && imem_ack_i;
    assign imem_hs      = raw_hs && !ignore_hs;

    // Hold stage 1 while imem has not answered or stage 2 is stuck
    assign stall_s1 = (imem_valid_o && !imem_hs) || stall_ex_i;

    // Nop into stage 2 on a jump, or when stage 2 drains but stage 1 has nothing
    assign flush = jump_i || (!stall_ex_i && stall_s1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ignore_hs <= 1'b0;
        end else if (!ignore_hs && jump_i) begin
            ignore_hs <= 1'b1;                      // Arm on a taken jump
        end else if (ignore_hs && raw_hs) begin
            ignore_hs <= 1'b0;                      // One handshake swallowed
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////////////////////
    assign pc_plus_four = pc + XLEN'(4);
    assign imem_addr_o  = pc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc <= RESET_PC;
        end else if (jump_i) begin
            pc <= {jump_target_i[XLEN-1:1], 1'b0};  // Halfword aligned target
        end else if (!stall_s1) begin
            pc <= pc_plus_four;
        end
    end

    // Address and link of the instruction moving into stage 2
    always_ff @(posedge clk_i) begin
        if (!stall_s1) begin
            pc_old_o    <= pc;
            link_addr_o <= pc_plus_four;
        end
    end

    // Instruction register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_o <= INSTR_NOP;
        end else if (flush) begin
            instr_o <= INSTR_NOP;                   // Bubble
        end else if (!stall_s1) begin
            instr_o <= imem_data_i;
        end
    end

endmodule

//--- atom_pkg.sv
// Atom RV32I core, shared definitions
// Widths, reset address, nop encoding, major opcodes and the
// control encodings passed from the decoder to the execute logic

package atom_pkg;

    localparam int XLEN       = 32;     // Data and address width
    localparam int REG_ADDR_W = 5;      // x0..x31

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;  // addi x0,x0,0

    ////////////////////////////////////////////////////////////////////////////
    // Major opcodes, instr[6:0]
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // ALU functions
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Comparator functions, ALWAYS for jumps, NEVER as default
    typedef enum logic [2:0] {
        CMP_ALWAYS,
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU,
        CMP_NEVER
    } cmp_op_e;

    // Register file write-back source
    typedef enum logic [1:0] {
        WB_IMM,     // lui
        WB_LINK,    // jal / jalr return address
        WB_ALU,
        WB_CMP      // slt / sltu result bit
    } wb_sel_e;

endpackage
